// File: Bender.yml
package:
  name: dual_fifo

sources:
  - common/dual_fifo_pkg.sv
  - hw/open_fifo4_bank.sv
  - open_fifo8/open_fifo8_2w2r.sv
  - hw/fifo_wb_regs.sv
  - hw/dual_fifo_top.sv
  - target: test
    files:
      - tb/fifo_checker.sv
      - tb/tb_dual_fifo.sv

// File: common/dual_fifo_pkg.sv
package dual_fifo_pkg;

  // Fixed geometry of two interleaved banks of four
  localparam int fifo_depth = 8;
  localparam int bank_depth = 4;

  // Occupancy 0..8
  typedef logic [3:0] cnt_t;

  // Register word addresses
  typedef enum logic [1:0] {
    reg_ctrl     = 2'd0,
    reg_status   = 2'd1,
    reg_clear    = 2'd2,
    reg_push_cnt = 2'd3
  } reg_addr_e;

  // Bit positions in reg_status, count sits in 3:0
  typedef enum int {
    stat_empty       = 4,
    stat_full        = 5,
    stat_almost_full = 6,
    stat_overflow    = 7,
    stat_underflow   = 8
  } status_bit_e;

  // reg_ctrl fields
  localparam int ctrl_flush_bit = 0;
  localparam int ctrl_thr_lsb   = 4;

  // reg_clear fields
  localparam int clr_ovf_bit = 0;
  localparam int clr_udf_bit = 1;

  // Almost-full threshold out of reset
  localparam cnt_t thresh_reset = 4'd6;

endpackage

// File: hw/dual_fifo_top.sv
`timescale 1ns/100ps

module dual_fifo_top #(
  parameter int DWIDTH = 32
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        push0,
  input  logic [DWIDTH-1:0]                           in_data0,
  input  logic                                        push1,
  input  logic [DWIDTH-1:0]                           in_data1,
  input  logic                                        pop0,
  input  logic                                        pop1,
  output logic [DWIDTH-1:0]                           out_data0,
  output logic [DWIDTH-1:0]                           out_data1,
  output logic [dual_fifo_pkg::fifo_depth*DWIDTH-1:0] win_data,
  output logic [dual_fifo_pkg::fifo_depth-1:0]        win_valid,
  output dual_fifo_pkg::cnt_t                         count,
  output logic                                        full,
  output logic                                        empty,
  output logic                                        almost_full,
  input  logic                                        wb_cyc,
  input  logic                                        wb_stb,
  input  logic                                        wb_we,
  input  logic [1:0]                                  wb_adr,
  input  logic [31:0]                                 wb_dat_w,
  output logic [31:0]                                 wb_dat_r,
  output logic                                        wb_ack
);

  logic       flush;
  logic       overflow_evt;
  logic       underflow_evt;
  logic [1:0] push_accepted;

  open_fifo8_2w2r #(.DWIDTH(DWIDTH)) i_fifo (
    .clk           (clk),
    .reset         (reset),
    .flush         (flush),
    .push0         (push0),
    .in_data0      (in_data0),
    .push1         (push1),
    .in_data1      (in_data1),
    .pop0          (pop0),
    .pop1          (pop1),
    .out_data0     (out_data0),
    .out_data1     (out_data1),
    .count         (count),
    .full          (full),
    .empty         (empty),
    .win_data      (win_data),
    .win_valid     (win_valid),
    .overflow_evt  (overflow_evt),
    .underflow_evt (underflow_evt),
    .push_accepted (push_accepted)
  );

  // Register block watches the FIFO status and drives flush back
  fifo_wb_regs i_regs (
    .clk           (clk),
    .reset         (reset),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .count         (count),
    .full          (full),
    .empty         (empty),
    .overflow_evt  (overflow_evt),
    .underflow_evt (underflow_evt),
    .push_accepted (push_accepted),
    .flush         (flush),
    .almost_full   (almost_full)
  );

endmodule

// File: hw/fifo_wb_regs.sv
`timescale 1ns/100ps

module fifo_wb_regs (
  input  logic                clk,
  input  logic                reset,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [1:0]          wb_adr,
  input  logic [31:0]         wb_dat_w,
  output logic [31:0]         wb_dat_r,
  output logic                wb_ack,
  input  dual_fifo_pkg::cnt_t count,
  input  logic                full,
  input  logic                empty,
  input  logic                overflow_evt,
  input  logic                underflow_evt,
  input  logic [1:0]          push_accepted,
  output logic                flush,
  output logic                almost_full
);

  import dual_fifo_pkg::*;

  logic        wb_req;
  logic        wr_en;
  reg_addr_e   addr;
  cnt_t        thresh;
  logic        ovf_flag;
  logic        udf_flag;
  logic [15:0] push_cnt;
  logic [31:0] rd_data;

  // New request only while ack is low, so acks never run back to back
  assign wb_req = wb_cyc && wb_stb && !wb_ack;
  assign wr_en  = wb_req && wb_we;
  assign addr   = reg_addr_e'(wb_adr);

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

  // Control register and flush pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      flush  <= 1'b0;
      thresh <= thresh_reset;
    end else begin
      flush <= wr_en && (addr == reg_ctrl) && wb_dat_w[ctrl_flush_bit];
      if (wr_en && (addr == reg_ctrl)) begin
        thresh <= wb_dat_w[ctrl_thr_lsb +: 4];
      end
    end
  end

  // Sticky flags, a new event beats a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      ovf_flag <= 1'b0;
      udf_flag <= 1'b0;
    end else begin
      if (wr_en && (addr == reg_clear) && wb_dat_w[clr_ovf_bit]) begin
        ovf_flag <= 1'b0;
      end
      if (wr_en && (addr == reg_clear) && wb_dat_w[clr_udf_bit]) begin
        udf_flag <= 1'b0;
      end
      if (overflow_evt) begin
        ovf_flag <= 1'b1;
      end
      if (underflow_evt) begin
        udf_flag <= 1'b1;
      end
    end
  end

  // Wraps at 16 bits
  always_ff @(posedge clk) begin
    if (reset) begin
      push_cnt <= '0;
    end else begin
      push_cnt <= push_cnt + 16'(push_accepted);
    end
  end

  assign almost_full = count >= thresh;

  always_comb begin
    rd_data = '0;
    unique case (addr)
      reg_ctrl: begin
        rd_data[ctrl_thr_lsb +: 4] = thresh;
      end
      reg_status: begin
        rd_data[3:0]              = count;
        rd_data[stat_empty]       = empty;
        rd_data[stat_full]        = full;
        rd_data[stat_almost_full] = almost_full;
        rd_data[stat_overflow]    = ovf_flag;
        rd_data[stat_underflow]   = udf_flag;
      end
      reg_clear: begin
        rd_data = '0;
      end
      reg_push_cnt: begin
        rd_data[15:0] = push_cnt;
      end
    endcase
  end

endmodule

// File: hw/open_fifo4_bank.sv
`timescale 1ns/100ps

module open_fifo4_bank #(
  parameter int DWIDTH = 32
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        flush,
  input  logic                                        push,
  input  logic [DWIDTH-1:0]                           in_data,
  input  logic                                        pop,
  output logic [DWIDTH-1:0]                           out_data,
  output logic                                        full,
  output logic                                        empty,
  output logic [dual_fifo_pkg::bank_depth*DWIDTH-1:0] entries,
  output logic [1:0]                                  rd_ptr,
  output logic [dual_fifo_pkg::bank_depth-1:0]        valid
);

  import dual_fifo_pkg::*;

  logic [DWIDTH-1:0] mem [bank_depth];
  logic [1:0]        wr_ptr;

  // Pointers and valid bits
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      valid  <= '0;
    end else begin
      if (pop) begin
        rd_ptr         <= rd_ptr + 2'd1;
        valid[rd_ptr]  <= 1'b0;
      end
      // A push into a full bank only comes with a pop of the same slot,
      // so the set below must win over the clear above
      if (push) begin
        wr_ptr         <= wr_ptr + 2'd1;
        valid[wr_ptr]  <= 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  assign out_data = mem[rd_ptr];
  assign full     = &valid;
  assign empty    = ~|valid;

  // Raw physical entries for the parent to reorder
  for (genvar i = 0; i < bank_depth; i++) begin : g_entries
    assign entries[i*DWIDTH +: DWIDTH] = mem[i];
  end

endmodule

// File: open_fifo8/open_fifo8_2w2r.sv
`timescale 1ns/100ps

module open_fifo8_2w2r #(
  parameter int DWIDTH = 32
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        flush,
  input  logic                                        push0,
  input  logic [DWIDTH-1:0]                           in_data0,
  input  logic                                        push1,
  input  logic [DWIDTH-1:0]                           in_data1,
  input  logic                                        pop0,
  input  logic                                        pop1,
  output logic [DWIDTH-1:0]                           out_data0,
  output logic [DWIDTH-1:0]                           out_data1,
  output dual_fifo_pkg::cnt_t                         count,
  output logic                                        full,
  output logic                                        empty,
  output logic [dual_fifo_pkg::fifo_depth*DWIDTH-1:0] win_data,
  output logic [dual_fifo_pkg::fifo_depth-1:0]        win_valid,
  output logic                                        overflow_evt,
  output logic                                        underflow_evt,
  output logic [1:0]                                  push_accepted
);

  import dual_fifo_pkg::*;

  logic                         push_swap;
  logic                         pop_swap;
  logic [1:0]                   n_push;
  logic [1:0]                   n_pop;
  cnt_t                         cnt_after_pop;
  cnt_t                         free_slots;
  logic                         push_ok;
  logic                         pop_ok;
  logic                         acc_push1;
  logic                         acc_pop1;
  logic                         push_even;
  logic                         push_odd;
  logic [DWIDTH-1:0]            in_even;
  logic [DWIDTH-1:0]            in_odd;
  logic                         pop_even;
  logic                         pop_odd;
  logic [DWIDTH-1:0]            out_even;
  logic [DWIDTH-1:0]            out_odd;
  logic                         full_even;
  logic                         full_odd;
  logic                         empty_even;
  logic                         empty_odd;
  logic [bank_depth*DWIDTH-1:0] entries_even;
  logic [bank_depth*DWIDTH-1:0] entries_odd;
  logic [1:0]                   rd_ptr_even;
  logic [1:0]                   rd_ptr_odd;
  logic [bank_depth-1:0]        valid_even;
  logic [bank_depth-1:0]        valid_odd;
  logic [2:0]                   head_idx;
  logic [DWIDTH-1:0]            phys [fifo_depth];

  assign count = cnt_t'($countones({valid_odd, valid_even}));
  assign full  = full_even && full_odd;
  assign empty = empty_even && empty_odd;

  // Lane 1 alone counts as nothing
  assign n_push = push0 ? (push1 ? 2'd2 : 2'd1) : 2'd0;
  assign n_pop  = pop0  ? (pop1  ? 2'd2 : 2'd1) : 2'd0;

  // Pop judged first, push sees the space the pop leaves behind
  assign underflow_evt = !flush && (cnt_t'(n_pop) > count);
  assign pop_ok        = !flush && pop0 && !underflow_evt;
  assign cnt_after_pop = pop_ok ? count - cnt_t'(n_pop) : count;
  assign free_slots    = cnt_t'(fifo_depth) - cnt_after_pop;
  assign overflow_evt  = !flush && (cnt_t'(n_push) > free_slots);
  assign push_ok       = !flush && push0 && !overflow_evt;
  assign push_accepted = push_ok ? n_push : 2'd0;

  assign acc_push1 = push_ok && push1;
  assign acc_pop1  = pop_ok && pop1;

  // Lane steering into the banks
  assign push_even = push_swap ? acc_push1 : push_ok;
  assign push_odd  = push_swap ? push_ok   : acc_push1;
  assign in_even   = push_swap ? in_data1  : in_data0;
  assign in_odd    = push_swap ? in_data0  : in_data1;
  assign pop_even  = pop_swap  ? acc_pop1  : pop_ok;
  assign pop_odd   = pop_swap  ? pop_ok    : acc_pop1;
  assign out_data0 = pop_swap  ? out_odd   : out_even;
  assign out_data1 = pop_swap  ? out_even  : out_odd;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      push_swap <= 1'b0;
      pop_swap  <= 1'b0;
    end else begin
      if (push_ok && !push1) begin
        push_swap <= ~push_swap;
      end
      if (pop_ok && !pop1) begin
        pop_swap <= ~pop_swap;
      end
    end
  end

  // Even bank holds physical slots 0,2,4,6 and odd bank 1,3,5,7
  for (genvar i = 0; i < bank_depth; i++) begin : g_phys
    assign phys[2*i]   = entries_even[i*DWIDTH +: DWIDTH];
    assign phys[2*i+1] = entries_odd[i*DWIDTH +: DWIDTH];
  end

  // Head slot is {bank pointer, bank}
  assign head_idx = pop_swap ? {rd_ptr_odd, 1'b1} : {rd_ptr_even, 1'b0};

  always_comb begin
    for (int k = 0; k < fifo_depth; k++) begin
      win_data[k*DWIDTH +: DWIDTH] = phys[3'(head_idx + k)];
      win_valid[k]                 = count > k;
    end
  end

  open_fifo4_bank #(.DWIDTH(DWIDTH)) bank_even (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .push     (push_even),
    .in_data  (in_even),
    .pop      (pop_even),
    .out_data (out_even),
    .full     (full_even),
    .empty    (empty_even),
    .entries  (entries_even),
    .rd_ptr   (rd_ptr_even),
    .valid    (valid_even)
  );

  open_fifo4_bank #(.DWIDTH(DWIDTH)) bank_odd (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .push     (push_odd),
    .in_data  (in_odd),
    .pop      (pop_odd),
    .out_data (out_odd),
    .full     (full_odd),
    .empty    (empty_odd),
    .entries  (entries_odd),
    .rd_ptr   (rd_ptr_odd),
    .valid    (valid_odd)
  );

endmodule

// File: sources.f
common/dual_fifo_pkg.sv
hw/open_fifo4_bank.sv
open_fifo8/open_fifo8_2w2r.sv
hw/fifo_wb_regs.sv
hw/dual_fifo_top.sv
tb/fifo_checker.sv
tb/tb_dual_fifo.sv

// File: tb/fifo_checker.sv
`timescale 1ns/100ps

module fifo_checker #(
  parameter int DWIDTH = 32
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  int                                          phase,
  input  logic                                        push0,
  input  logic [DWIDTH-1:0]                           in_data0,
  input  logic                                        push1,
  input  logic [DWIDTH-1:0]                           in_data1,
  input  logic                                        pop0,
  input  logic                                        pop1,
  input  logic [DWIDTH-1:0]                           out_data0,
  input  logic [DWIDTH-1:0]                           out_data1,
  input  logic [dual_fifo_pkg::fifo_depth*DWIDTH-1:0] win_data,
  input  logic [dual_fifo_pkg::fifo_depth-1:0]        win_valid,
  input  dual_fifo_pkg::cnt_t                         count,
  input  logic                                        full,
  input  logic                                        empty,
  input  logic                                        almost_full,
  input  logic                                        wb_cyc,
  input  logic                                        wb_stb,
  input  logic                                        wb_we,
  input  logic [1:0]                                  wb_adr,
  input  logic [31:0]                                 wb_dat_w,
  input  logic [31:0]                                 wb_dat_r,
  input  logic                                        wb_ack,
  output int                                          checks,
  output int                                          errors
);

  import dual_fifo_pkg::*;

  logic [DWIDTH-1:0]     q [$];
  logic [3:0]            thresh;
  logic                  ovf;
  logic                  udf;
  logic [15:0]           push_cnt;
  logic                  flush_q;
  logic                  exp_ack;
  logic                  exp_rd_valid;
  logic                  wb_req;
  logic [31:0]           exp_rd;
  logic                  ov_ev;
  logic                  un_ev;
  int                    n_push;
  int                    n_pop;
  logic [fifo_depth-1:0] exp_valid;
  int                    n_checks = 0;
  int                    n_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  function automatic string phase_name(input int p);
    case (p)
      1: return "random_traffic";
      2: return "overflow_underflow";
      3: return "lone_lane1";
      4: return "flush";
      5: return "threshold";
      6: return "push_counter";
      default: return "reset";
    endcase
  endfunction

  // Register contents as seen before the current edge
  function automatic logic [31:0] reg_value(input logic [1:0] adr);
    logic [31:0] v;
    int          n;
    v = '0;
    n = q.size();
    case (adr)
      reg_ctrl: v[7:4] = thresh;
      reg_status: begin
        v[3:0] = n;
        v[4]   = (n == 0);
        v[5]   = (n == fifo_depth);
        v[6]   = (n >= thresh);
        v[7]   = ovf;
        v[8]   = udf;
      end
      reg_push_cnt: v[15:0] = push_cnt;
      default: v = '0;
    endcase
    return v;
  endfunction

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("ERROR %s %s: expected %0h, actual %0h at %0t",
               phase_name(phase), what, exp, act, $time);
    end
  endtask

  // Model update at each edge, pop judged before push
  always @(posedge clk) begin
    if (reset) begin
      q.delete();
      thresh       = 4'd6;
      ovf          = 1'b0;
      udf          = 1'b0;
      push_cnt     = '0;
      flush_q      = 1'b0;
      exp_ack      = 1'b0;
      exp_rd_valid = 1'b0;
    end else begin
      wb_req       = wb_cyc && wb_stb && !exp_ack;
      exp_rd_valid = wb_req && !wb_we;
      if (exp_rd_valid) begin
        exp_rd = reg_value(wb_adr);
      end
      n_push = push0 ? (push1 ? 2 : 1) : 0;
      n_pop  = pop0 ? (pop1 ? 2 : 1) : 0;
      ov_ev  = 1'b0;
      un_ev  = 1'b0;
      if (flush_q) begin
        q.delete();
      end else begin
        if (n_pop > q.size()) begin
          un_ev = 1'b1;
        end else begin
          repeat (n_pop) q.delete(0);
        end
        if (n_push > fifo_depth - q.size()) begin
          ov_ev = 1'b1;
        end else begin
          if (n_push > 0) q.push_back(in_data0);
          if (n_push > 1) q.push_back(in_data1);
          push_cnt = push_cnt + 16'(n_push);
        end
      end
      flush_q = wb_req && wb_we && (wb_adr == reg_ctrl) && wb_dat_w[0];
      if (wb_req && wb_we && (wb_adr == reg_ctrl)) begin
        thresh = wb_dat_w[7:4];
      end
      if (wb_req && wb_we && (wb_adr == reg_clear)) begin
        if (wb_dat_w[0]) ovf = 1'b0;
        if (wb_dat_w[1]) udf = 1'b0;
      end
      if (ov_ev) ovf = 1'b1;
      if (un_ev) udf = 1'b1;
      exp_ack = wb_req;
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      compare("count", q.size(), count);
      compare("empty", q.size() == 0, empty);
      compare("full", q.size() == fifo_depth, full);
      compare("almost_full", q.size() >= thresh, almost_full);
      for (int k = 0; k < fifo_depth; k++) begin
        exp_valid[k] = (q.size() > k);
      end
      compare("win_valid", exp_valid, win_valid);
      for (int k = 0; k < q.size(); k++) begin
        compare($sformatf("win_data[%0d]", k), q[k], win_data[k*DWIDTH +: DWIDTH]);
      end
      if (q.size() > 0) compare("out_data0", q[0], out_data0);
      if (q.size() > 1) compare("out_data1", q[1], out_data1);
      compare("wb_ack", exp_ack, wb_ack);
      if (exp_ack && exp_rd_valid) begin
        compare("wb_dat_r", exp_rd, wb_dat_r);
      end
    end
  end

endmodule

// File: tb/tb_dual_fifo.sv
`timescale 1ns/100ps

module tb_dual_fifo;

  import dual_fifo_pkg::*;

  localparam int DWIDTH = 32;
  // Random traffic, 40 threshold rounds of about 15 cycles, directed phases
  localparam int test_cycles = 2000 + 130 + 40 * 15 + 150;
  localparam int timeout_ns  = test_cycles * 10 + 5000;

  logic                         clk;
  logic                         reset;
  logic                         push0;
  logic [DWIDTH-1:0]            in_data0;
  logic                         push1;
  logic [DWIDTH-1:0]            in_data1;
  logic                         pop0;
  logic                         pop1;
  logic [DWIDTH-1:0]            out_data0;
  logic [DWIDTH-1:0]            out_data1;
  logic [fifo_depth*DWIDTH-1:0] win_data;
  logic [fifo_depth-1:0]        win_valid;
  cnt_t                         count;
  logic                         full;
  logic                         empty;
  logic                         almost_full;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [1:0]                   wb_adr;
  logic [31:0]                  wb_dat_w;
  logic [31:0]                  wb_dat_r;
  logic                         wb_ack;
  integer                       seed;
  int                           phase;
  int                           tb_errors;
  int                           checks;
  int                           errors;
  logic [31:0]                  thr;

  dual_fifo_top #(.DWIDTH(DWIDTH)) i_dual_fifo_top (.*);

  fifo_checker #(.DWIDTH(DWIDTH)) i_fifo_checker (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
    $display(">>> FAIL");
    $finish;
  end

  task automatic lane_cycle(input logic p0, input logic p1, input logic q0, input logic q1);
    push0    <= p0;
    push1    <= p1;
    pop0     <= q0;
    pop1     <= q1;
    in_data0 <= $random(seed);
    in_data1 <= $random(seed);
    @(posedge clk);
  endtask

  task automatic random_traffic(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      // About three in four cycles use lane 0 on each side
      lane_cycle(r[0] | r[1], r[2], r[3] | r[4], r[5]);
    end
  endtask

  task automatic wb_access(input logic we, input reg_addr_e adr, input logic [31:0] wdata);
    int n;
    n = 0;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do begin
      @(posedge clk);
      n++;
    end while (!wb_ack && n < 8);
    if (!wb_ack) begin
      tb_errors++;
      $display("Wishbone access to address %0d never got an ack", adr);
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  initial begin
    reset     = 1'b1;
    push0     = 1'b0;
    push1     = 1'b0;
    pop0      = 1'b0;
    pop1      = 1'b0;
    in_data0  = '0;
    in_data1  = '0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    phase     = 0;
    tb_errors = 0;
    seed      = 32'h6cb6;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    phase <= 1;
    random_traffic(2000);

    // Overflow with one free slot and when full, then underflow
    phase <= 2;
    lane_cycle(0, 0, 0, 0);
    wb_access(1'b1, reg_ctrl, 32'h61);
    wb_access(1'b1, reg_clear, 32'h3);
    repeat (7) lane_cycle(1, 0, 0, 0);
    lane_cycle(1, 1, 0, 0);
    lane_cycle(0, 0, 0, 0);
    wb_access(1'b0, reg_status, 32'h0);
    wb_access(1'b1, reg_clear, 32'h1);
    lane_cycle(1, 0, 0, 0);
    lane_cycle(1, 0, 0, 0);
    lane_cycle(0, 0, 0, 0);
    wb_access(1'b0, reg_status, 32'h0);
    wb_access(1'b1, reg_clear, 32'h1);
    wb_access(1'b1, reg_ctrl, 32'h61);
    lane_cycle(1, 0, 0, 0);
    lane_cycle(0, 0, 1, 1);
    lane_cycle(0, 0, 0, 0);
    wb_access(1'b0, reg_status, 32'h0);
    wb_access(1'b1, reg_clear, 32'h2);
    lane_cycle(0, 0, 1, 0);
    lane_cycle(0, 0, 1, 0);
    lane_cycle(0, 0, 0, 0);
    wb_access(1'b0, reg_status, 32'h0);
    wb_access(1'b1, reg_clear, 32'h2);
    wb_access(1'b0, reg_status, 32'h0);

    phase <= 3;
    wb_access(1'b1, reg_clear, 32'h3);
    repeat (3) lane_cycle(0, 1, 0, 0);
    repeat (8) lane_cycle(1, 0, 0, 0);
    lane_cycle(0, 1, 0, 1);
    repeat (3) lane_cycle(0, 0, 0, 1);
    lane_cycle(0, 0, 0, 0);
    wb_access(1'b0, reg_status, 32'h0);

    // Lanes keep pushing through the whole flush access
    phase <= 4;
    random_traffic(30);
    lane_cycle(1, 0, 1, 1);
    wb_access(1'b1, reg_ctrl, 32'h61);
    random_traffic(100);

    phase <= 5;
    repeat (40) begin
      thr = $random(seed);
      lane_cycle(0, 0, 0, 0);
      wb_access(1'b1, reg_ctrl, {24'h0, thr[3:0], 4'h0});
      wb_access(1'b0, reg_ctrl, 32'h0);
      random_traffic(8);
    end

    phase <= 6;
    lane_cycle(0, 0, 0, 0);
    wb_access(1'b0, reg_push_cnt, 32'h0);
    repeat (3) @(posedge clk);

    $display("Checks: %0d, mismatches: %0d, other failures: %0d", checks, errors, tb_errors);
    if (errors == 0 && tb_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
